//--- vlog.f
+incdir+rtl
rtl/rt_pixel_pkg.sv
rtl/rt_geom_pkg.sv
rtl/render_ctrl.sv
rtl/ray_gen.sv
rtl/aabb_hit.sv
rtl/pixel_fifo.sv
rtl/frame_writer.sv
rtl/rt_top.sv
sim/tb_clock.sv
sim/rt_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= rt_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/100ps
PASS_TEXT ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/rt_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "rt_settings.svh"

module rt_tb;

	localparam int NUM_ROWS = 5;
	localparam int RESET_CYCLES = 2;
	localparam int STRAY_START_CYCLE = 40;
	// Four times a sparse-ready frame for every row
	localparam int CYCLE_LIMIT = 4 * NUM_ROWS * (`RT_NUM_PIXELS + 20) * 4;

	typedef enum logic [1:0] {
		READY_ALWAYS,
		READY_RANDOM,
		READY_SPARSE
	} ready_mode_t;

	typedef struct packed {
		rt_geom_pkg::aabb_t box;
		rt_geom_pkg::coord_t eye_z;
		rt_pixel_pkg::color_t box_color;
		ready_mode_t ready_mode;
	} frame_row_t;

	logic clk;
	logic rst_n;
	logic start;
	rt_geom_pkg::aabb_t box;
	rt_geom_pkg::coord_t eye_z;
	rt_pixel_pkg::color_t box_color;
	logic fb_ready;
	logic fb_we;
	rt_pixel_pkg::pixel_addr_t fb_addr;
	rt_pixel_pkg::color_t fb_data;
	logic busy;
	logic done;

	frame_row_t frames [NUM_ROWS];
	rt_pixel_pkg::color_t got_frame [`RT_NUM_PIXELS];
	integer seed;
	int cycle_cnt;
	int value_errors;
	int protocol_errors;

	tb_clock #(.PERIOD(20)) clk_gen (.clk);

	rt_top dut_i (
		.clk,
		.rst_n,
		.start,
		.box,
		.eye_z,
		.box_color,
		.fb_ready,
		.fb_we,
		.fb_addr,
		.fb_data,
		.busy,
		.done
	);

	function automatic frame_row_t make_row(input rt_geom_pkg::aabb_t b,
		input rt_geom_pkg::coord_t ez, input rt_pixel_pkg::color_t col, input ready_mode_t m);
		frame_row_t r;
		r.box = b;
		r.eye_z = ez;
		r.box_color = col;
		r.ready_mode = m;
		return r;
	endfunction

	// Reference model of the slab test and the depth shade
	function automatic rt_pixel_pkg::color_t expected_color(input frame_row_t row,
		input rt_geom_pkg::coord_t x, input rt_geom_pkg::coord_t y);
		rt_pixel_pkg::color_t c;
		int t_near;
		int ch;
		bit hit;
		hit = (x >= row.box.xmin) && (x <= row.box.xmax) && (y >= row.box.ymin)
			&& (y <= row.box.ymax) && (row.box.zmax >= row.eye_z);
		if (!hit)
			return `RT_BG_COLOR;
		t_near = (row.box.zmin > row.eye_z) ? int'(row.box.zmin) - int'(row.eye_z) : 0;
		for (int i = 0; i < 3; i++) begin
			ch = int'(row.box_color[i*8 +: 8]) - t_near;
			if (ch < 0)
				ch = 0;
			c[i*8 +: 8] = 8'(ch);
		end
		return c;
	endfunction

	task automatic compare_color(input string name, input rt_pixel_pkg::color_t got,
		input rt_pixel_pkg::color_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input rt_pixel_pkg::pixel_addr_t got,
		input rt_pixel_pkg::pixel_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic expect_count(input string name, input int got, input int exp);
		if (got != exp) begin
			value_errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_protocol(input string what);
		protocol_errors++;
		$display("Error: %s", what);
	endtask

	task automatic drive_ready(input ready_mode_t mode, input int cyc);
		case (mode)
			READY_RANDOM: fb_ready = ($random(seed) & 1) != 0;
			// One ready cycle in four
			READY_SPARSE: fb_ready = (cyc % 4 == 0);
			default: fb_ready = 1'b1;
		endcase
	endtask

	task automatic run_frame(input int idx);
		frame_row_t row;
		int writes;
		int dones;
		int next_addr;
		int cyc;
		bit seen_done;
		row = frames[idx];
		writes = 0;
		dones = 0;
		next_addr = 0;
		cyc = 0;
		seen_done = 1'b0;
		for (int a = 0; a < `RT_NUM_PIXELS; a++)
			got_frame[a] = 'x;
		box = row.box;
		eye_z = row.eye_z;
		box_color = row.box_color;
		start = 1'b1;
		while (!seen_done) begin
			@(negedge clk);
			cyc++;
			// fb_we here follows the fb_ready applied during the cycle just ended
			if (fb_we) begin
				if (!fb_ready)
					report_protocol("fb_we high after a cycle with fb_ready low");
				check_addr("fb_addr", fb_addr, rt_pixel_pkg::pixel_addr_t'(next_addr));
				if (int'(fb_addr) < `RT_NUM_PIXELS)
					got_frame[fb_addr] = fb_data;
				next_addr++;
				writes++;
			end
			if (done) begin
				dones++;
				seen_done = 1'b1;
				if (busy)
					report_protocol("busy still high in the done cycle");
			end else if (!busy) begin
				report_protocol("busy low while the frame is in progress");
			end
			// Stray start in mid-frame must be ignored
			start = (cyc == STRAY_START_CYCLE);
			drive_ready(row.ready_mode, cyc);
		end
		start = 1'b0;
		repeat (3) begin
			@(negedge clk);
			if (fb_we)
				report_protocol("write after the end of the frame");
			if (done)
				dones++;
			if (busy)
				report_protocol("busy high after done");
		end
		expect_count("write count", writes, `RT_NUM_PIXELS);
		expect_count("done count", dones, 1);
		for (int a = 0; a < `RT_NUM_PIXELS; a++)
			compare_color($sformatf("fb_data[%0d]", a), got_frame[a],
				expected_color(row, rt_geom_pkg::coord_t'(a % `RT_WIDTH),
				rt_geom_pkg::coord_t'(a / `RT_WIDTH)));
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: frames did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		seed = 32'h68a9915e;
		value_errors = 0;
		protocol_errors = 0;
		rst_n = 1'b0;
		start = 1'b0;
		box = '0;
		eye_z = '0;
		box_color = '0;
		fb_ready = 1'b0;

		// Box fields in order xmin ymin zmin xmax ymax zmax
		frames[0] = make_row(rt_geom_pkg::aabb_t'{8'd3, 8'd2, 8'd20, 8'd10, 8'd8, 8'd40},
			8'd10, 24'hc08040, READY_ALWAYS);
		// Deep box whose channels clip at black
		frames[1] = make_row(rt_geom_pkg::aabb_t'{8'd0, 8'd4, 8'd100, 8'd5, 8'd11, 8'd120},
			8'd0, 24'h60ff20, READY_ALWAYS);
		// Eye inside the box gives full color
		frames[2] = make_row(rt_geom_pkg::aabb_t'{8'd8, 8'd0, 8'd5, 8'd15, 8'd5, 8'd50},
			8'd30, 24'h33aa77, READY_RANDOM);
		// Box behind the eye
		frames[3] = make_row(rt_geom_pkg::aabb_t'{8'd0, 8'd0, 8'd2, 8'd15, 8'd11, 8'd8},
			8'd50, 24'hffffff, READY_SPARSE);
		// Box off the screen
		frames[4] = make_row(rt_geom_pkg::aabb_t'{8'd40, 8'd20, 8'd0, 8'd60, 8'd30, 8'd255},
			8'd0, 24'h808080, READY_RANDOM);

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		if (fb_we || busy || done)
			report_protocol("outputs not idle after reset");
		rst_n = 1'b1;
		fb_ready = 1'b1;
		@(negedge clk);

		for (int i = 0; i < NUM_ROWS; i++)
			run_frame(i);

		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- rtl/rt_top.sv
`default_nettype none
`timescale 1ns/100ps

module rt_top (
	input logic clk,
	input logic rst_n,
	input logic start,
	input rt_geom_pkg::aabb_t box,
	input rt_geom_pkg::coord_t eye_z,
	input rt_pixel_pkg::color_t box_color,
	input logic fb_ready,
	output logic fb_we,
	output rt_pixel_pkg::pixel_addr_t fb_addr,
	output rt_pixel_pkg::color_t fb_data,
	output logic busy,
	output logic done
);

	// Controller to ray generator
	logic pix_valid;
	rt_geom_pkg::coord_t pix_x;
	rt_geom_pkg::coord_t pix_y;
	rt_pixel_pkg::pixel_addr_t pix_addr;

	// Ray pipe
	logic ray_valid;
	rt_geom_pkg::ray_t ray;
	logic shade_valid;
	rt_pixel_pkg::pixel_entry_t shade_entry;

	// FIFO to writer with pop as the credit return
	logic fifo_empty;
	rt_pixel_pkg::pixel_entry_t fifo_head;
	logic pop;

	render_ctrl ctrl (
		.clk,
		.rst_n,
		.start,
		.pop,
		.pix_valid,
		.pix_x,
		.pix_y,
		.pix_addr,
		.busy,
		.done
	);

	ray_gen rg (
		.clk,
		.rst_n,
		.pix_valid,
		.pix_x,
		.pix_y,
		.pix_addr,
		.eye_z,
		.ray_valid,
		.ray
	);

	aabb_hit hit (
		.clk,
		.rst_n,
		.ray_valid,
		.ray,
		.box,
		.box_color,
		.shade_valid,
		.entry(shade_entry)
	);

	pixel_fifo pb (
		.clk,
		.rst_n,
		.wr(shade_valid),
		.rd(pop),
		.wr_entry(shade_entry),
		.rd_entry(fifo_head),
		.empty(fifo_empty)
	);

	frame_writer fbw (
		.clk,
		.rst_n,
		.fb_ready,
		.empty(fifo_empty),
		.head(fifo_head),
		.pop,
		.fb_we,
		.fb_addr,
		.fb_data
	);

endmodule

`default_nettype wire

//--- rtl/frame_writer.sv
`default_nettype none
`timescale 1ns/100ps

module frame_writer (
	input logic clk,
	input logic rst_n,
	input logic fb_ready,
	input logic empty,
	input rt_pixel_pkg::pixel_entry_t head,
	output logic pop,
	output logic fb_we,
	output rt_pixel_pkg::pixel_addr_t fb_addr,
	output rt_pixel_pkg::color_t fb_data
);

	// Take the head only when memory will accept it
	assign pop = fb_ready && !empty;

	always_ff @(posedge clk) begin
		if (!rst_n)
			fb_we <= 1'b0;
		else
			fb_we <= pop;
	end

	// Address and data held until the next pop
	always_ff @(posedge clk) begin
		if (pop) begin
			fb_addr <= head.addr;
			fb_data <= head.color;
		end
	end

endmodule

`default_nettype wire

//--- rtl/pixel_fifo.sv
`default_nettype none
`timescale 1ns/100ps
`include "rt_settings.svh"

module pixel_fifo #(
	parameter int DEPTH = `RT_FIFO_DEPTH
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic rd,
	input rt_pixel_pkg::pixel_entry_t wr_entry,
	output rt_pixel_pkg::pixel_entry_t rd_entry,
	output logic empty
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	rt_pixel_pkg::pixel_entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	// Head is visible without a read request
	assign rd_entry = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_entry;
	end

	// Pointers wrap on their own since DEPTH is a power of two
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/aabb_hit.sv
`default_nettype none
`timescale 1ns/100ps
`include "rt_settings.svh"

module aabb_hit (
	input logic clk,
	input logic rst_n,
	input logic ray_valid,
	input rt_geom_pkg::ray_t ray,
	input rt_geom_pkg::aabb_t box,
	input rt_pixel_pkg::color_t box_color,
	output logic shade_valid,
	output rt_pixel_pkg::pixel_entry_t entry
);

	logic in_x;
	logic in_y;
	logic in_z;
	rt_geom_pkg::coord_t t_near;

	logic s1_valid;
	logic s1_hit;
	rt_geom_pkg::coord_t s1_t_near;
	rt_pixel_pkg::pixel_addr_t s1_addr;

	// Darken each channel by the entry distance, floor at black
	function automatic rt_pixel_pkg::color_t depth_shade(
		input rt_pixel_pkg::color_t c,
		input rt_geom_pkg::coord_t t
	);
		rt_pixel_pkg::color_t r;
		logic [7:0] ch;
		for (int i = 0; i < 3; i++) begin
			ch = c[i*8 +: 8];
			r[i*8 +: 8] = (ch > t) ? ch - t : 8'd0;
		end
		return r;
	endfunction

	// A +z ray only crosses the x and y slabs if it starts inside them
	assign in_x = (ray.orig_x >= box.xmin) && (ray.orig_x <= box.xmax);
	assign in_y = (ray.orig_y >= box.ymin) && (ray.orig_y <= box.ymax);
	// Box must not lie wholly behind the eye
	assign in_z = (box.zmax >= ray.orig_z);
	assign t_near = (box.zmin > ray.orig_z) ? box.zmin - ray.orig_z : '0;

	// Stage 1
	always_ff @(posedge clk) begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= ray_valid;
	end

	always_ff @(posedge clk) begin
		s1_hit <= in_x && in_y && in_z;
		s1_t_near <= t_near;
		s1_addr <= ray.addr;
	end

	// Stage 2
	always_ff @(posedge clk) begin
		if (!rst_n)
			shade_valid <= 1'b0;
		else
			shade_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		entry.addr <= s1_addr;
		entry.color <= s1_hit ? depth_shade(box_color, s1_t_near) : `RT_BG_COLOR;
	end

endmodule

`default_nettype wire

//--- rtl/ray_gen.sv
`default_nettype none
`timescale 1ns/100ps

module ray_gen (
	input logic clk,
	input logic rst_n,
	input logic pix_valid,
	input rt_geom_pkg::coord_t pix_x,
	input rt_geom_pkg::coord_t pix_y,
	input rt_pixel_pkg::pixel_addr_t pix_addr,
	input rt_geom_pkg::coord_t eye_z,
	output logic ray_valid,
	output rt_geom_pkg::ray_t ray
);

	always_ff @(posedge clk) begin
		if (!rst_n)
			ray_valid <= 1'b0;
		else
			ray_valid <= pix_valid;
	end

	// Pixel grid maps straight onto the x/y plane at the eye depth
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			ray.orig_x <= pix_x;
			ray.orig_y <= pix_y;
			ray.orig_z <= eye_z;
			ray.addr <= pix_addr;
		end
	end

endmodule

`default_nettype wire

//--- rtl/render_ctrl.sv
`default_nettype none
`timescale 1ns/100ps
`include "rt_settings.svh"

module render_ctrl (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic pop,
	output logic pix_valid,
	output rt_geom_pkg::coord_t pix_x,
	output rt_geom_pkg::coord_t pix_y,
	output rt_pixel_pkg::pixel_addr_t pix_addr,
	output logic busy,
	output logic done
);

	localparam int CREDIT_W = $clog2(`RT_FIFO_DEPTH + 1);

	rt_pixel_pkg::ctrl_state_t state;
	logic [CREDIT_W-1:0] credits;
	rt_pixel_pkg::pixel_addr_t pop_cnt;
	logic last_x;
	logic last_pix;
	logic last_pop;

	// One free FIFO slot per credit, so issuing never overflows it
	assign pix_valid = (state == rt_pixel_pkg::CTRL_ISSUE) && (credits != '0);
	assign busy = (state != rt_pixel_pkg::CTRL_IDLE);

	assign last_x = (pix_x == rt_geom_pkg::coord_t'(`RT_WIDTH - 1));
	assign last_pix = (pix_addr == rt_pixel_pkg::pixel_addr_t'(`RT_NUM_PIXELS - 1));
	assign last_pop = pop && (pop_cnt == rt_pixel_pkg::pixel_addr_t'(`RT_NUM_PIXELS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= rt_pixel_pkg::CTRL_IDLE;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				rt_pixel_pkg::CTRL_IDLE: begin
					if (start)
						state <= rt_pixel_pkg::CTRL_ISSUE;
				end
				rt_pixel_pkg::CTRL_ISSUE: begin
					if (pix_valid && last_pix)
						state <= rt_pixel_pkg::CTRL_DRAIN;
				end
				rt_pixel_pkg::CTRL_DRAIN: begin
					// Frame ends when the last pixel leaves the FIFO
					if (last_pop) begin
						state <= rt_pixel_pkg::CTRL_IDLE;
						done <= 1'b1;
					end
				end
				default: state <= rt_pixel_pkg::CTRL_IDLE;
			endcase
		end
	end

	// Raster walk, parked at the origin between frames
	always_ff @(posedge clk) begin
		if (!rst_n || state == rt_pixel_pkg::CTRL_IDLE) begin
			pix_x <= '0;
			pix_y <= '0;
			pix_addr <= '0;
		end else if (pix_valid) begin
			pix_addr <= pix_addr + 1'b1;
			if (last_x) begin
				pix_x <= '0;
				pix_y <= pix_y + 1'b1;
			end else begin
				pix_x <= pix_x + 1'b1;
			end
		end
	end

	// Credits come back as the writer pops
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= CREDIT_W'(`RT_FIFO_DEPTH);
			pop_cnt <= '0;
		end else begin
			case ({pix_valid, pop})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			if (state == rt_pixel_pkg::CTRL_IDLE)
				pop_cnt <= '0;
			else if (pop)
				pop_cnt <= pop_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rt_geom_pkg.sv
`default_nettype none

package rt_geom_pkg;

	// Unsigned integer grid coordinate
	typedef logic [7:0] coord_t;

	// Axis-aligned box, inclusive bounds
	typedef struct packed {
		coord_t xmin;
		coord_t ymin;
		coord_t zmin;
		coord_t xmax;
		coord_t ymax;
		coord_t zmax;
	} aabb_t;

	// Orthographic ray along +z, tagged with its frame address
	typedef struct packed {
		coord_t orig_x;
		coord_t orig_y;
		coord_t orig_z;
		rt_pixel_pkg::pixel_addr_t addr;
	} ray_t;

endpackage

`default_nettype wire

//--- rtl/rt_pixel_pkg.sv
`default_nettype none

package rt_pixel_pkg;

	// 8 bits per channel, red in the top byte
	typedef logic [23:0] color_t;

	// Linear frame address, one word per pixel
	typedef logic [7:0] pixel_addr_t;

	// What the FIFO carries toward the frame memory
	typedef struct packed {
		pixel_addr_t addr;
		color_t color;
	} pixel_entry_t;

	// Render controller states
	typedef enum logic [1:0] {
		CTRL_IDLE = 2'd0,
		CTRL_ISSUE = 2'd1,
		CTRL_DRAIN = 2'd2
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/rt_settings.svh
`ifndef RT_SETTINGS_SVH
`define RT_SETTINGS_SVH

// Screen size in pixels
`define RT_WIDTH 16
`define RT_HEIGHT 12

// One ray per pixel, raster order
`define RT_NUM_PIXELS (`RT_WIDTH * `RT_HEIGHT)

// Pixel FIFO depth, power of two
`define RT_FIFO_DEPTH 8

// Color for pixels that miss the box
`define RT_BG_COLOR 24'h102040

`endif
